// File: hdl/biquad_consts.svh
`ifndef BIQUAD_CONSTS_SVH
`define BIQUAD_CONSTS_SVH

// --------------------------------------------------
// word widths
// --------------------------------------------------
// audio sample in and out
`define BQ_IN_W 24
// parameter word, coefficient and delay-line state
`define BQ_COEF_W 32
// full product and accumulator
`define BQ_ACC_W 64

// coefficients are Q2.30
`define BQ_FRAC 30
// sample sits 8 bits up in the state word, scale is Q2.30, so 30 - 8
`define BQ_SCALE_SHIFT 22

// --------------------------------------------------
// parameter map
// --------------------------------------------------
`define BQ_ADDR_W 3
`define BQ_ADDR_B0 3'd0
`define BQ_ADDR_B1 3'd1
`define BQ_ADDR_B2 3'd2
`define BQ_ADDR_A1 3'd3
`define BQ_ADDR_A2 3'd4
`define BQ_ADDR_SCALE 3'd5
// address 6 is a hole in the map
`define BQ_ADDR_COMMIT 3'd7

// 1.0 in Q2.30, reset value of b0 and scale
`define BQ_ONE 32'sh4000_0000

`endif

// File: hdl/biquad_pkg.sv
`default_nettype none

`include "biquad_consts.svh"

package biquad_pkg;

  typedef logic signed [`BQ_IN_W-1:0]   sample_t;   // audio sample
  typedef logic signed [`BQ_COEF_W-1:0] state_t;    // delay-line word
  typedef logic signed [`BQ_COEF_W-1:0] coef_t;     // Q2.30
  typedef logic signed [`BQ_ACC_W-1:0]  acc_t;      // products and sums
  typedef logic [`BQ_ADDR_W-1:0]        par_addr_t; // parameter address

  // clamp limits of a state word, held in accumulator width
  localparam acc_t STATE_MAX = (acc_t'(1) <<< (`BQ_COEF_W - 1)) - acc_t'(1);
  localparam acc_t STATE_MIN = -STATE_MAX - acc_t'(1);

  // saturate a wide value into a state word
  function automatic state_t sat_state(input acc_t v);
    state_t r;
    if (v > STATE_MAX) begin
      r = state_t'(STATE_MAX); // clip high
    end else if (v < STATE_MIN) begin
      r = state_t'(STATE_MIN); // clip low
    end else begin
      r = state_t'(v);         // in range, low word
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// File: hdl/coef_if.sv
`timescale 1ns/100ps
`default_nettype none

// active coefficient set, bank to datapath
interface coef_if import biquad_pkg::*; ();

  coef_t b0; // feed-forward, current input
  coef_t b1; // feed-forward, x[n-1]
  coef_t b2; // feed-forward, x[n-2]
  coef_t a1; // feedback, y[n-1]
  coef_t a2; // feedback, y[n-2]

  // register side
  modport bank (
    output b0, b1, b2, a1, a2
  );

  // datapath side
  modport core (
    input b0, b1, b2, a1, a2
  );

endinterface

`default_nettype wire

// File: hdl/coef_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "biquad_consts.svh"

module coef_bank import biquad_pkg::*; (
  input  logic      Clk_CI,
  input  logic      Rst_RBI,
  input  logic      wr_en,  // one write per edge
  input  par_addr_t addr,
  input  coef_t     par_in,
  output coef_t     scale,  // active input scale
  coef_if.bank      coefs   // active filter set
);

  localparam int NPAR = 6; // b0 b1 b2 a1 a2 scale

  // reset value per address, passthrough set
  function automatic coef_t par_default(input int unsigned a);
    coef_t v;
    if (a == `BQ_ADDR_B0 || a == `BQ_ADDR_SCALE) begin
      v = `BQ_ONE;
    end else begin
      v = '0;
    end
    return v;
  endfunction

  coef_t [0:NPAR-1] stage_q; // software side
  coef_t [0:NPAR-1] act_q;   // filter side
  logic             commit;

  assign commit = wr_en && (addr == `BQ_ADDR_COMMIT); // data word ignored

  // --------------------------------------------------
  // staged registers
  // --------------------------------------------------
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      for (int i = 0; i < NPAR; i++) begin
        stage_q[i] <= par_default(i);
      end
    end else if (wr_en) begin
      for (int i = 0; i < NPAR; i++) begin
        if (addr == par_addr_t'(i)) begin
          stage_q[i] <= par_in; // commit and hole never match
        end
      end
    end
  end

  // --------------------------------------------------
  // active registers, all six move on one edge
  // --------------------------------------------------
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      for (int i = 0; i < NPAR; i++) begin
        act_q[i] <= par_default(i);
      end
    end else if (commit) begin
      act_q <= stage_q; // staged values before this edge's write
    end
  end

  assign coefs.b0 = act_q[`BQ_ADDR_B0];
  assign coefs.b1 = act_q[`BQ_ADDR_B1];
  assign coefs.b2 = act_q[`BQ_ADDR_B2];
  assign coefs.a1 = act_q[`BQ_ADDR_A1];
  assign coefs.a2 = act_q[`BQ_ADDR_A2];
  assign scale    = act_q[`BQ_ADDR_SCALE];

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  // address 6 has no register behind it
  a_no_hole_wr: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    wr_en |-> (addr != par_addr_t'(6)))
    else $error("write to unused parameter address 6");

  // datapath never sees a half-updated set
  a_act_stable: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    !commit |=> $stable(act_q))
    else $error("active coefficients changed without commit");

endmodule

`default_nettype wire

// File: hdl/input_scaler.sv
`timescale 1ns/100ps
`default_nettype none

`include "biquad_consts.svh"

module input_scaler import biquad_pkg::*; (
  input  logic    Clk_CI,
  input  logic    Rst_RBI,
  input  sample_t sample_in,
  input  coef_t   scale,     // Q2.30
  output state_t  x0,        // x[n], combinational
  output state_t  x1,        // x[n-1]
  output state_t  x2         // x[n-2]
);

  sample_t in_q;   // registered input sample
  acc_t    prod;   // 24 x 32, fits with room
  state_t  x1_q;
  state_t  x2_q;

  // --------------------------------------------------
  // input register
  // --------------------------------------------------
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      in_q <= '0; // keeps x0 at 0 during reset
    end else begin
      in_q <= sample_in;
    end
  end

  // scale, then drop to Q.8 inside the state word
  assign prod = acc_t'(in_q) * acc_t'(scale);
  assign x0   = sat_state(prod >>> `BQ_SCALE_SHIFT); // clamps when scale > 1

  // --------------------------------------------------
  // input delay line
  // --------------------------------------------------
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      x1_q <= '0;
      x2_q <= '0;
    end else begin
      x1_q <= x0;   // shifts every edge
      x2_q <= x1_q;
    end
  end

  assign x1 = x1_q;
  assign x2 = x2_q;

  // delay line tracks the scaled sample, one edge behind
  a_x1_follows: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    1'b1 |=> (x1 == $past(x0)))
    else $error("x1 does not hold previous x0");

endmodule

`default_nettype wire

// File: hdl/biquad_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "biquad_consts.svh"

module biquad_core import biquad_pkg::*; (
  input  logic    Clk_CI,
  input  logic    Rst_RBI,
  coef_if.core    coefs,      // active set from the bank
  input  state_t  x0,         // x[n]
  input  state_t  x1,         // x[n-1]
  input  state_t  x2,         // x[n-2]
  output sample_t sample_out  // top of y[n-1]
);

  // products, full width
  acc_t p_b0;
  acc_t p_b1;
  acc_t p_b2;
  acc_t p_a1;
  acc_t p_a2;

  acc_t ff_sum; // feed-forward part
  acc_t fb_sum; // feedback part
  acc_t acc;    // before truncation

  state_t y;    // y[n]
  state_t y1_q; // y[n-1]
  state_t y2_q; // y[n-2]

  // --------------------------------------------------
  // feed-forward
  // --------------------------------------------------
  // sign extension through the signed casts
  assign p_b0 = acc_t'(coefs.b0) * acc_t'(x0);
  assign p_b1 = acc_t'(coefs.b1) * acc_t'(x1);
  assign p_b2 = acc_t'(coefs.b2) * acc_t'(x2);

  assign ff_sum = p_b0 + p_b1 + p_b2; // Q.30 scaled by state

  // --------------------------------------------------
  // feedback
  // --------------------------------------------------
  assign p_a1 = acc_t'(coefs.a1) * acc_t'(y1_q);
  assign p_a2 = acc_t'(coefs.a2) * acc_t'(y2_q);

  assign fb_sum = p_a1 + p_a2; // subtracted, a0 normalised to 1

  // --------------------------------------------------
  // accumulate and truncate
  // --------------------------------------------------
  assign acc = ff_sum - fb_sum;
  assign y   = sat_state(acc >>> `BQ_FRAC); // arithmetic, drops Q2.30 fraction

  // --------------------------------------------------
  // output delay line
  // --------------------------------------------------
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      y1_q <= '0;
      y2_q <= '0;
    end else begin
      y1_q <= y;    // every edge
      y2_q <= y1_q;
    end
  end

  // output from the registered sample, not from y
  assign sample_out = y1_q[`BQ_COEF_W-1 -: `BQ_IN_W];

  // whole chain from pins to output must be initialised out of reset
  a_out_known: assert property (@(posedge Clk_CI)
    Rst_RBI |-> !$isunknown(sample_out))
    else $error("sample_out has unknown bits");

endmodule

`default_nettype wire

// File: hdl/biquad_filter_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "biquad_consts.svh"

module biquad_filter_top import biquad_pkg::*; (
  input  logic                  Clk_CI,
  input  logic                  Rst_RBI,
  input  logic                  wr_en,      // parameter write strobe
  input  logic [`BQ_ADDR_W-1:0] addr,       // parameter address
  input  logic [`BQ_COEF_W-1:0] par_in,     // parameter data
  input  logic [`BQ_IN_W-1:0]   sample_in,  // one sample per clock
  output logic [`BQ_IN_W-1:0]   sample_out  // two edges behind the input
);

  coef_t  scale; // active input scale
  state_t x0;    // scaled sample
  state_t x1;
  state_t x2;

  coef_if coefs ();

  // --------------------------------------------------
  // parameter registers
  // --------------------------------------------------
  coef_bank coef_bank_i (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .wr_en   (wr_en),
    .addr    (addr),
    .par_in  (par_in),
    .scale   (scale),
    .coefs   (coefs.bank)
  );

  // --------------------------------------------------
  // input side
  // --------------------------------------------------
  input_scaler input_scaler_i (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .sample_in (sample_in),
    .scale     (scale),
    .x0        (x0),
    .x1        (x1),
    .x2        (x2)
  );

  // --------------------------------------------------
  // filter datapath
  // --------------------------------------------------
  biquad_core biquad_core_i (
    .Clk_CI     (Clk_CI),
    .Rst_RBI    (Rst_RBI),
    .coefs      (coefs.core),
    .x0         (x0),
    .x1         (x1),
    .x2         (x2),
    .sample_out (sample_out)
  );

endmodule

`default_nettype wire

// File: testbench/tb_biquad_filter.sv
`timescale 1ns/100ps
`default_nettype none

`include "biquad_consts.svh"

module tb_biquad_filter;

  localparam int MAX_CYCLES = 2000; // stimulus runs about 1400 cycles

  // low-pass at fs/10 with Q of 1 in Q2.30
  localparam logic signed [31:0] LP_B0 = 32'sd79242000;
  localparam logic signed [31:0] LP_B1 = 32'sd158484000;
  localparam logic signed [31:0] LP_B2 = 32'sd79242000;
  localparam logic signed [31:0] LP_A1 = -32'sd1342714000;
  localparam logic signed [31:0] LP_A2 = 32'sd585941000;
  localparam logic signed [31:0] SC_HALF = 32'sh2000_0000; // 0.5
  localparam logic signed [31:0] SC_175  = 32'sh7000_0000; // 1.75

  logic        Clk_CI;
  logic        Rst_RBI;
  logic        wr_en;
  logic [`BQ_ADDR_W-1:0] addr;
  logic [`BQ_COEF_W-1:0] par_in;
  logic [`BQ_IN_W-1:0]   sample_in;
  logic [`BQ_IN_W-1:0]   sample_out;

  // reference model state
  logic signed [31:0] m_stage [0:5]; // staged copy
  logic signed [31:0] m_act [0:5];   // active copy
  logic signed [23:0] m_in;          // input register
  logic signed [31:0] m_x1;
  logic signed [31:0] m_x2;
  logic signed [31:0] m_y1;
  logic signed [31:0] m_y2;
  logic signed [63:0] x_raw;         // scaled value before clamp
  logic signed [31:0] x0_m;
  logic signed [31:0] y_m;
  logic [23:0] in_d1;                // sample_in one edge back
  logic [23:0] in_d2;                // two edges back
  logic        pass_chk;             // passthrough rule active

  logic [31:0] lfsr;
  int          cyc = 0;
  int          n_checks = 0;
  int          sat_x = 0; // clipped scaled inputs
  int          sat_y = 0; // clipped outputs

  biquad_filter_top biquad_filter_top_i (
    .Clk_CI     (Clk_CI),
    .Rst_RBI    (Rst_RBI),
    .wr_en      (wr_en),
    .addr       (addr),
    .par_in     (par_in),
    .sample_in  (sample_in),
    .sample_out (sample_out)
  );

  always #50 Clk_CI = ~Clk_CI; // 100 ns period

  // --------------------------------------------------
  // reference arithmetic
  // --------------------------------------------------
  function automatic logic signed [31:0] clamp_state(input logic signed [63:0] v);
    logic signed [31:0] r;
    if (v > 64'sd2147483647) begin
      r = 32'sh7fff_ffff;
    end else if (v < -64'sd2147483648) begin
      r = 32'sh8000_0000;
    end else begin
      r = v[31:0];
    end
    return r;
  endfunction

  // direct form I with a0 taken as 1
  function automatic logic signed [31:0] biquad_ref(
    input logic signed [31:0] x0, x1, x2, y1, y2,
    input logic signed [31:0] b0, b1, b2, a1, a2
  );
    logic signed [63:0] acc;
    acc = 64'(b0) * 64'(x0) + 64'(b1) * 64'(x1) + 64'(b2) * 64'(x2)
        - 64'(a1) * 64'(y1) - 64'(a2) * 64'(y2);
    return clamp_state(acc >>> 30); // drop coefficient fraction
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic next_sample(output logic [23:0] v);
    v = '0;
    for (int i = 0; i < 24; i++) begin
      lfsr = lfsr_step(lfsr); // one step per bit
      v = {v[22:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t ns %s: got %h expected %h", $time, sig, got, exp);
      $display("Simulation failed");
      $fatal(1, "compare mismatch on %s", sig);
    end
  endtask

  task automatic reset_model();
    for (int i = 0; i < 6; i++) begin
      m_stage[i] = (i == `BQ_ADDR_B0 || i == `BQ_ADDR_SCALE) ? `BQ_ONE : 32'sd0;
      m_act[i]   = m_stage[i]; // passthrough defaults
    end
    m_in  = '0;
    m_x1  = '0;
    m_x2  = '0;
    m_y1  = '0;
    m_y2  = '0;
    in_d1 = '0;
    in_d2 = '0;
  endtask

  // --------------------------------------------------
  // compare and model step on every rising edge
  // --------------------------------------------------
  always @(posedge Clk_CI) begin
    if (!Rst_RBI) begin
      reset_model();
    end else begin
      check_value("sample_out", {8'h00, sample_out}, {8'h00, m_y1[31:8]});
      if (pass_chk) begin
        check_value("sample_out", {8'h00, sample_out}, {8'h00, in_d2}); // 2-edge delay
      end
      n_checks++;
      x_raw = (64'(m_in) * 64'(m_act[`BQ_ADDR_SCALE])) >>> `BQ_SCALE_SHIFT;
      x0_m  = clamp_state(x_raw);
      if (64'(x0_m) != x_raw) begin
        sat_x++;
      end
      y_m = biquad_ref(x0_m, m_x1, m_x2, m_y1, m_y2,
                       m_act[`BQ_ADDR_B0], m_act[`BQ_ADDR_B1], m_act[`BQ_ADDR_B2],
                       m_act[`BQ_ADDR_A1], m_act[`BQ_ADDR_A2]); // old set this edge
      if (y_m == 32'sh7fff_ffff || y_m == 32'sh8000_0000) begin
        sat_y++;
      end
      m_y2  = m_y1;
      m_y1  = y_m;
      m_x2  = m_x1;
      m_x1  = x0_m;
      m_in  = sample_in;
      in_d2 = in_d1;
      in_d1 = sample_in;
      if (wr_en) begin
        if (addr == `BQ_ADDR_COMMIT) begin
          for (int i = 0; i < 6; i++) begin
            m_act[i] = m_stage[i]; // all six at once
          end
        end else if (addr < 3'd6) begin
          m_stage[addr] = par_in;
        end
      end
    end
  end

  // run limit
  always @(posedge Clk_CI) begin
    cyc++;
    if (cyc >= MAX_CYCLES) begin
      $display("run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  // --------------------------------------------------
  // stimulus driven on the falling edge
  // --------------------------------------------------
  task automatic drive_random(input int n);
    logic [23:0] s;
    repeat (n) begin
      next_sample(s);
      @(negedge Clk_CI);
      wr_en     = 1'b0;
      sample_in = s;
    end
  endtask

  task automatic drive_const(input logic [23:0] v, input int n);
    repeat (n) begin
      @(negedge Clk_CI);
      wr_en     = 1'b0;
      sample_in = v;
    end
  endtask

  task automatic write_param(input logic [2:0] a, input logic [31:0] d);
    logic [23:0] s;
    next_sample(s);
    @(negedge Clk_CI);
    wr_en     = 1'b1;
    addr      = a;
    par_in    = d;
    sample_in = s; // samples keep flowing
  endtask

  initial begin
    Clk_CI    = 1'b0;
    Rst_RBI   = 1'b0;
    wr_en     = 1'b0;
    addr      = '0;
    par_in    = '0;
    sample_in = '0;
    pass_chk  = 1'b0;
    lfsr      = 32'hd6fa;
    repeat (5) @(negedge Clk_CI);
    Rst_RBI  = 1'b1;
    pass_chk = 1'b1;

    drive_random(200); // defaults pass the input through

    // staged only so the output must not move
    write_param(`BQ_ADDR_B0, LP_B0);
    write_param(`BQ_ADDR_B1, LP_B1);
    write_param(`BQ_ADDR_B2, LP_B2);
    write_param(`BQ_ADDR_A1, LP_A1);
    write_param(`BQ_ADDR_A2, LP_A2);
    write_param(`BQ_ADDR_SCALE, `BQ_ONE);
    drive_random(40);

    // low-pass live
    pass_chk = 1'b0;
    write_param(`BQ_ADDR_COMMIT, 32'hdead_beef); // data word ignored
    drive_random(300);
    drive_const(24'h40_0000, 150);
    drive_const(24'hc0_0000, 150);

    write_param(`BQ_ADDR_SCALE, SC_HALF);
    write_param(`BQ_ADDR_COMMIT, 32'h0);
    drive_random(100);

    // full-scale square wave clips x and the overshoot of y
    write_param(`BQ_ADDR_SCALE, SC_175);
    write_param(`BQ_ADDR_COMMIT, 32'h0);
    repeat (4) begin
      drive_const(24'h7f_ffff, 32);
      drive_const(24'h80_0000, 32);
    end

    // mid-run reset back to passthrough
    @(negedge Clk_CI);
    Rst_RBI = 1'b0;
    wr_en   = 1'b0;
    repeat (3) @(negedge Clk_CI);
    Rst_RBI  = 1'b1;
    pass_chk = 1'b1;
    drive_random(75);
    write_param(`BQ_ADDR_COMMIT, 32'h0); // staged set is back at defaults too
    drive_random(75);
    drive_const(24'h0, 3); // flush the pipeline

    if (sat_x == 0 || sat_y == 0 || n_checks < 1000) begin
      $display("saturation never reached or too few compares (%0d)", n_checks);
      $display("Simulation failed");
      $fatal(1, "incomplete coverage of the test");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
hdl/biquad_pkg.sv
hdl/coef_if.sv
hdl/coef_bank.sv
hdl/input_scaler.sv
hdl/biquad_core.sv
hdl/biquad_filter_top.sv
testbench/tb_biquad_filter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the biquad testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_biquad_filter
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module "$TOP" -Mdir "$OBJ" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
